/* axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // the bridge always drives id 1 on this width
    localparam int AXI_ID_WIDTH = 4;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,  // address past the end of the array
        DECERR = 2'b11
    } axi_resp_e;

    // unprivileged secure data access, all prot bits clear
    localparam logic [2:0] AXI_PROT_DATA = 3'b000;

    // normal non-cacheable non-bufferable
    localparam logic [3:0] AXI_CACHE_NORMAL = 4'b0010;

endpackage

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int XLEN       = 64;
    localparam int ADDR_WIDTH = 32;
    localparam int STRB_WIDTH = XLEN / 8;

    // same code as AxSIZE once zero extended
    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } lsu_size_e;

    // store sequence
    typedef enum logic [2:0] {
        W_IDLE,
        W_AW,
        W_DATA,
        W_RESP,
        W_DONE
    } wr_state_e;

    // load sequence
    typedef enum logic [1:0] {
        R_IDLE,
        R_AR,
        R_DATA,
        R_DONE
    } rd_state_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WDATA,
        S_WAIT,
        S_RESP
    } slv_state_e;

endpackage

`default_nettype wire

/* latency_timer.sv */
`default_nettype none

module latency_timer #(
    parameter int MEM_LATENCY = 3
) (
    input  wire  clock,
    input  wire  reset,
    input  wire  start_i,
    output logic done_o
);

    logic [3:0] count;  // 0 when idle

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            count  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= (count == 4'd1);  // last step of the countdown
            if (start_i) begin
                count <= 4'(MEM_LATENCY);
            end else if (count != 4'd0) begin
                count <= count - 4'd1;
            end
        end
    end

    // the slave only starts a new delay once the previous one ran out
    a_no_restart: assert property (@(posedge clock) disable iff (!reset)
        start_i |-> count == 4'd0);

endmodule

`default_nettype wire

/* lsu_data_align.sv */
`default_nettype none

module lsu_data_align
    import lsu_pkg::*;
(
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   capture_i,
    input  wire                   rdata_capture_i,
    input  wire [ADDR_WIDTH-1:0]  req_addr_i,
    input  wire lsu_size_e        req_size_i,
    input  wire [XLEN-1:0]        req_wdata_i,
    input  wire [XLEN-1:0]        r_data_i,
    output logic [ADDR_WIDTH-1:0] addr_o,
    output logic [2:0]            size_o,
    output logic [XLEN-1:0]       w_data_o,
    output logic [STRB_WIDTH-1:0] w_strb_o,
    output logic [XLEN-1:0]       rsp_rdata_o
);

    logic [ADDR_WIDTH-1:0] addr_q;
    lsu_size_e             size_q;
    logic [XLEN-1:0]       wdata_q;
    logic [XLEN-1:0]       rdata_q;  // raw R beat, all lanes
    logic [5:0]            shamt;    // lane offset in bits

    function automatic logic [STRB_WIDTH-1:0] size_strb(lsu_size_e size);
        case (size)
            BYTE:    return STRB_WIDTH'(1);
            HALF:    return STRB_WIDTH'(3);
            WORD:    return STRB_WIDTH'(15);
            default: return '1;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] size_mask(lsu_size_e size);
        case (size)
            BYTE:    return {{(XLEN-8){1'b0}}, {8{1'b1}}};
            HALF:    return {{(XLEN-16){1'b0}}, {16{1'b1}}};
            WORD:    return {{(XLEN-32){1'b0}}, {32{1'b1}}};
            default: return '1;
        endcase
    endfunction

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            addr_q <= '0;
            size_q <= BYTE;
        end else if (capture_i) begin
            addr_q <= req_addr_i;
            size_q <= req_size_i;
        end
    end

    always_ff @(posedge clock) begin
        if (capture_i) begin
            wdata_q <= req_wdata_i;
        end
        if (rdata_capture_i) begin
            rdata_q <= r_data_i;
        end
    end

    assign shamt = {addr_q[2:0], 3'b000};

    assign addr_o   = addr_q;          // shared by AW and AR
    assign size_o   = {1'b0, size_q};
    assign w_data_o = wdata_q << shamt;
    assign w_strb_o = size_strb(size_q) << addr_q[2:0];

    // back down to bit 0, zero extended
    assign rsp_rdata_o = (rdata_q >> shamt) & size_mask(size_q);

    // the core must never issue a misaligned access
    a_aligned: assert property (@(posedge clock) disable iff (!reset)
        capture_i |=> ({1'b0, addr_q[2:0]} & ((4'd1 << size_q) - 4'd1)) == 4'd0);

endmodule

`default_nettype wire

/* lsu_ctrl_fsm.sv */
`default_nettype none

module lsu_ctrl_fsm
    import axi_pkg::*;
    import lsu_pkg::*;
(
    input  wire            clock,
    input  wire            reset,
    input  wire            req_valid_i,
    input  wire            req_write_i,
    input  wire            aw_ready_i,
    input  wire            w_ready_i,
    input  wire            b_valid_i,
    input  wire axi_resp_e b_resp_i,
    input  wire            ar_ready_i,
    input  wire            r_valid_i,
    input  wire axi_resp_e r_resp_i,
    input  wire            rsp_ready_i,
    output logic           req_ready_o,
    output logic           aw_valid_o,
    output logic           w_valid_o,
    output logic           b_ready_o,
    output logic           ar_valid_o,
    output logic           r_ready_o,
    output logic           capture_o,
    output logic           rdata_capture_o,
    output logic           rsp_valid_o,
    output logic           rsp_write_o,
    output logic           rsp_error_o
);

    wr_state_e wr_state;
    wr_state_e wr_state_next;
    rd_state_e rd_state;
    rd_state_e rd_state_next;
    logic      accept;
    logic      err_q;  // bresp or rresp was not OKAY

    assign req_ready_o = (wr_state == W_IDLE) && (rd_state == R_IDLE);
    assign accept      = req_valid_i && req_ready_o;
    assign capture_o   = accept;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state <= W_IDLE;
            rd_state <= R_IDLE;
        end else begin
            wr_state <= wr_state_next;
            rd_state <= rd_state_next;
        end
    end

    always_comb begin
        wr_state_next = wr_state;
        case (wr_state)
            W_IDLE: begin
                if (accept && req_write_i) begin
                    wr_state_next = W_AW;
                end
            end
            W_AW: begin
                if (aw_ready_i) begin
                    wr_state_next = W_DATA;
                end
            end
            W_DATA: begin
                if (w_ready_i) begin
                    wr_state_next = W_RESP;
                end
            end
            W_RESP: begin
                if (b_valid_i) begin
                    wr_state_next = W_DONE;
                end
            end
            W_DONE: begin
                if (rsp_ready_i) begin
                    wr_state_next = W_IDLE;
                end
            end
            default: wr_state_next = W_IDLE;
        endcase
    end

    always_comb begin
        rd_state_next = rd_state;
        case (rd_state)
            R_IDLE: begin
                if (accept && !req_write_i) begin
                    rd_state_next = R_AR;
                end
            end
            R_AR: begin
                if (ar_ready_i) begin
                    rd_state_next = R_DATA;
                end
            end
            R_DATA: begin
                if (r_valid_i) begin
                    rd_state_next = R_DONE;
                end
            end
            R_DONE: begin
                if (rsp_ready_i) begin
                    rd_state_next = R_IDLE;
                end
            end
            default: rd_state_next = R_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            err_q <= 1'b0;
        end else if (b_valid_i && b_ready_o) begin
            err_q <= (b_resp_i != OKAY);
        end else if (r_valid_i && r_ready_o) begin
            err_q <= (r_resp_i != OKAY);
        end
    end

    assign aw_valid_o      = (wr_state == W_AW);
    assign w_valid_o       = (wr_state == W_DATA);
    assign b_ready_o       = (wr_state == W_RESP);
    assign ar_valid_o      = (rd_state == R_AR);
    assign r_ready_o       = (rd_state == R_DATA);
    assign rdata_capture_o = r_valid_i && r_ready_o;  // load beat into aligner

    assign rsp_valid_o = (wr_state == W_DONE) || (rd_state == R_DONE);
    assign rsp_write_o = (wr_state == W_DONE);
    assign rsp_error_o = err_q;

    a_aw_hold: assert property (@(posedge clock) disable iff (!reset)
        aw_valid_o && !aw_ready_i |=> aw_valid_o);

    a_ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o);

    // one transaction in flight
    a_one_active: assert property (@(posedge clock) disable iff (!reset)
        !((wr_state != W_IDLE) && (rd_state != R_IDLE)));

endmodule

`default_nettype wire

/* axi_mem_slave.sv */
`default_nettype none

module axi_mem_slave
    import axi_pkg::*;
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   aw_valid_i,
    input  wire [ADDR_WIDTH-1:0]  aw_addr_i,
    input  wire                   w_valid_i,
    input  wire [XLEN-1:0]        w_data_i,
    input  wire [STRB_WIDTH-1:0]  w_strb_i,
    input  wire                   b_ready_i,
    input  wire                   ar_valid_i,
    input  wire [ADDR_WIDTH-1:0]  ar_addr_i,
    input  wire                   r_ready_i,
    output logic                  aw_ready_o,
    output logic                  w_ready_o,
    output logic                  b_valid_o,
    output axi_resp_e             b_resp_o,
    output logic                  ar_ready_o,
    output logic                  r_valid_o,
    output axi_resp_e             r_resp_o,
    output logic [XLEN-1:0]       r_data_o
);

    localparam int IDX_W  = $clog2(MEM_WORDS);
    localparam int WIDX_W = ADDR_WIDTH - 3;  // word index bits of an address

    logic [XLEN-1:0]  mem [MEM_WORDS];
    slv_state_e       state;
    logic             is_write;  // kind of the current transaction
    logic             err_q;
    logic [IDX_W-1:0] idx_q;     // write word, from AW
    logic [XLEN-1:0]  rdata_q;
    logic             aw_hs;
    logic             w_hs;
    logic             ar_hs;
    logic             aw_err;
    logic             ar_err;
    logic             timer_done;

    assign aw_ready_o = (state == S_IDLE);
    assign ar_ready_o = (state == S_IDLE) && !aw_valid_i;  // writes win
    assign w_ready_o  = (state == S_WDATA);

    assign aw_hs = aw_valid_i && aw_ready_o;
    assign w_hs  = w_valid_i && w_ready_o;
    assign ar_hs = ar_valid_i && ar_ready_o;

    assign aw_err = aw_addr_i[ADDR_WIDTH-1:3] >= WIDX_W'(MEM_WORDS);
    assign ar_err = ar_addr_i[ADDR_WIDTH-1:3] >= WIDX_W'(MEM_WORDS);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= S_IDLE;
            is_write <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (aw_hs) begin
                        state    <= S_WDATA;
                        is_write <= 1'b1;
                        err_q    <= aw_err;
                    end else if (ar_hs) begin
                        state    <= S_WAIT;
                        is_write <= 1'b0;
                        err_q    <= ar_err;
                    end
                end
                S_WDATA: begin
                    if (w_hs) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (timer_done) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (is_write ? b_ready_i : r_ready_i) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            idx_q <= aw_addr_i[3 +: IDX_W];
        end
    end

    // strobed write on W, read snapshot on AR
    always_ff @(posedge clock) begin
        if (w_hs && !err_q) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (w_strb_i[b]) begin
                    mem[idx_q][b*8 +: 8] <= w_data_i[b*8 +: 8];
                end
            end
        end
        if (ar_hs) begin
            rdata_q <= ar_err ? '0 : mem[ar_addr_i[3 +: IDX_W]];
        end
    end

    latency_timer #(
        .MEM_LATENCY (MEM_LATENCY)
    ) timer_i (
        .clock   (clock),
        .reset   (reset),
        .start_i (w_hs || ar_hs),
        .done_o  (timer_done)
    );

    assign b_valid_o = (state == S_RESP) && is_write;
    assign r_valid_o = (state == S_RESP) && !is_write;
    assign b_resp_o  = err_q ? SLVERR : OKAY;
    assign r_resp_o  = err_q ? SLVERR : OKAY;
    assign r_data_o  = rdata_q;

    a_one_resp: assert property (@(posedge clock) disable iff (!reset)
        !(b_valid_o && r_valid_o));

endmodule

`default_nettype wire

/* lsu_axi_top.sv */
`default_nettype none

module lsu_axi_top
    import axi_pkg::*;
    import lsu_pkg::*;
#(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  req_valid_i,
    output wire                  req_ready_o,
    input  wire                  req_write_i,
    input  wire [ADDR_WIDTH-1:0] req_addr_i,
    input  wire lsu_size_e       req_size_i,
    input  wire [XLEN-1:0]       req_wdata_i,
    output wire                  rsp_valid_o,
    input  wire                  rsp_ready_i,
    output wire                  rsp_write_o,
    output wire [XLEN-1:0]       rsp_rdata_o,
    output wire                  rsp_error_o
);

    wire                  awvalid;
    wire                  awready;
    wire                  wvalid;
    wire                  wready;
    wire                  bvalid;
    wire                  bready;
    axi_resp_e            bresp;
    wire                  arvalid;
    wire                  arready;
    wire                  rvalid;
    wire                  rready;
    axi_resp_e            rresp;
    wire [XLEN-1:0]       rdata;
    wire [ADDR_WIDTH-1:0] axaddr;  // awaddr and araddr
    wire [XLEN-1:0]       wdata;
    wire [STRB_WIDTH-1:0] wstrb;
    wire                  capture;
    wire                  rdata_capture;

    lsu_ctrl_fsm ctrl_i (
        .clock           (clock),
        .reset           (reset),
        .req_valid_i     (req_valid_i),
        .req_write_i     (req_write_i),
        .aw_ready_i      (awready),
        .w_ready_i       (wready),
        .b_valid_i       (bvalid),
        .b_resp_i        (bresp),
        .ar_ready_i      (arready),
        .r_valid_i       (rvalid),
        .r_resp_i        (rresp),
        .rsp_ready_i     (rsp_ready_i),
        .req_ready_o     (req_ready_o),
        .aw_valid_o      (awvalid),
        .w_valid_o       (wvalid),
        .b_ready_o       (bready),
        .ar_valid_o      (arvalid),
        .r_ready_o       (rready),
        .capture_o       (capture),
        .rdata_capture_o (rdata_capture),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_write_o     (rsp_write_o),
        .rsp_error_o     (rsp_error_o)
    );

    lsu_data_align align_i (
        .clock           (clock),
        .reset           (reset),
        .capture_i       (capture),
        .rdata_capture_i (rdata_capture),
        .req_addr_i      (req_addr_i),
        .req_size_i      (req_size_i),
        .req_wdata_i     (req_wdata_i),
        .r_data_i        (rdata),
        .addr_o          (axaddr),
        .size_o          (),  // slave works from the strobes alone
        .w_data_o        (wdata),
        .w_strb_o        (wstrb),
        .rsp_rdata_o     (rsp_rdata_o)
    );

    axi_mem_slave #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) mem_i (
        .clock      (clock),
        .reset      (reset),
        .aw_valid_i (awvalid),
        .aw_addr_i  (axaddr),
        .w_valid_i  (wvalid),
        .w_data_i   (wdata),
        .w_strb_i   (wstrb),
        .b_ready_i  (bready),
        .ar_valid_i (arvalid),
        .ar_addr_i  (axaddr),
        .r_ready_i  (rready),
        .aw_ready_o (awready),
        .w_ready_o  (wready),
        .b_valid_o  (bvalid),
        .b_resp_o   (bresp),
        .ar_ready_o (arready),
        .r_valid_o  (rvalid),
        .r_resp_o   (rresp),
        .r_data_o   (rdata)
    );

endmodule

`default_nettype wire

/* tb_lsu_axi.sv */
`default_nettype none

module tb_lsu_axi
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS   = 256;
    localparam int MEM_LATENCY = 3;
    localparam int SEED        = 26067;
    localparam int N_PER_SIZE  = 300;  // round trips per access size
    localparam int N_OOR       = 32;
    localparam int MAX_HOLD    = 5;    // longest rsp_ready_i stall
    // fill, then store + load + double load per round trip, then three per range test
    localparam int N_TRANS        = MEM_WORDS + 4 * N_PER_SIZE * 3 + N_OOR * 3;
    localparam int TIMEOUT_CYCLES = N_TRANS * (MEM_LATENCY + 10 + MAX_HOLD) + 20;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  req_valid;
    logic                  req_ready_o;
    logic                  req_write;
    logic [ADDR_WIDTH-1:0] req_addr;
    lsu_size_e             req_size;
    logic [XLEN-1:0]       req_wdata;
    logic                  rsp_valid_o;
    logic                  rsp_ready;
    logic                  rsp_write_o;
    logic [XLEN-1:0]       rsp_rdata_o;
    logic                  rsp_error_o;

    logic [7:0] model_mem [MEM_WORDS*8];  // byte image of the slave
    int         n_errors = 0;
    int         n_checks = 0;
    int         cycle_count = 0;

    lsu_axi_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) dut_i (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready_o),
        .req_write_i (req_write),
        .req_addr_i  (req_addr),
        .req_size_i  (req_size),
        .req_wdata_i (req_wdata),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready),
        .rsp_write_o (rsp_write_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_error_o (rsp_error_o)
    );

    always #5 clock = ~clock;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // little endian bytes, zero extended
    function automatic logic [XLEN-1:0] model_load(input int addr, input int nbytes);
        logic [XLEN-1:0] value;
        value = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[i*8 +: 8] = model_mem[addr + i];
        end
        return value;
    endfunction

    function automatic void model_store(input int addr, input int nbytes,
                                        input logic [XLEN-1:0] data);
        for (int i = 0; i < nbytes; i++) begin
            model_mem[addr + i] = data[i*8 +: 8];
        end
    endfunction

    function automatic int rand_addr(input int nbytes);
        int word;
        int offset;
        word   = int'($urandom % MEM_WORDS);
        offset = int'($urandom % (8 / nbytes)) * nbytes;  // natural alignment
        return word * 8 + offset;
    endfunction

    // one request through to its response, with a random response stall
    task automatic access(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                          input lsu_size_e size, input logic [XLEN-1:0] wdata,
                          output logic [XLEN-1:0] rdata, output logic error);
        int              hold;
        logic [XLEN-1:0] held_rdata;
        logic            held_write;
        logic            held_error;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_size  = size;
        req_wdata = wdata;
        while (!req_ready_o) begin
            @(posedge clock);
            #1;
        end
        @(posedge clock);  // request transfers here
        #1;
        req_valid = 1'b0;
        while (!rsp_valid_o) begin
            @(posedge clock);
            #1;
        end
        check("rsp_write_o", 64'(write), 64'(rsp_write_o));
        held_rdata = rsp_rdata_o;
        held_write = rsp_write_o;
        held_error = rsp_error_o;
        hold = int'($urandom % (MAX_HOLD + 1));
        repeat (hold) begin
            @(posedge clock);
            #1;
            check("rsp_valid_o", 64'(1), 64'(rsp_valid_o));
            check("rsp_rdata_o", held_rdata, rsp_rdata_o);
            check("rsp_write_o", 64'(held_write), 64'(rsp_write_o));
            check("rsp_error_o", 64'(held_error), 64'(rsp_error_o));
            check("req_ready_o", 64'(0), 64'(req_ready_o));
        end
        rsp_ready = 1'b1;
        @(posedge clock);
        #1;
        rsp_ready = 1'b0;
        check("rsp_valid_o", 64'(0), 64'(rsp_valid_o));  // exactly one response
        rdata = held_rdata;
        error = held_error;
    endtask

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        int                  addr;
        int                  nbytes;
        logic [XLEN-1:0]     data;
        logic [XLEN-1:0]     rdata;
        logic                error;
        logic [ADDR_WIDTH-4:0] widx;

        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS * 8; i++) begin
            model_mem[i] = 8'h00;
        end

        reset     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_size  = BYTE;
        req_wdata = '0;
        rsp_ready = 1'b0;

        repeat (5) begin
            @(posedge clock);
            #1;
            check("rsp_valid_o", 64'(0), 64'(rsp_valid_o));
            check("req_ready_o", 64'(1), 64'(req_ready_o));
        end
        reset = 1'b1;
        @(posedge clock);
        #1;
        check("rsp_valid_o", 64'(0), 64'(rsp_valid_o));
        check("req_ready_o", 64'(1), 64'(req_ready_o));

        // slave array has no reset, so give every word a known value
        for (int w = 0; w < MEM_WORDS; w++) begin
            data = {32'(w) * 32'h9e37_79b9, ~32'(w)};
            access(1'b1, ADDR_WIDTH'(w * 8), DOUBLE, data, rdata, error);
            check("rsp_error_o", 64'(0), 64'(error));
            model_store(w * 8, 8, data);
        end

        for (int s = 0; s < 4; s++) begin
            nbytes = 1 << s;
            for (int n = 0; n < N_PER_SIZE; n++) begin
                addr = rand_addr(nbytes);
                data = {$urandom, $urandom};  // upper bits must not leak
                access(1'b1, ADDR_WIDTH'(addr), lsu_size_e'(2'(s)), data, rdata, error);
                check("rsp_error_o", 64'(0), 64'(error));
                model_store(addr, nbytes, data);

                access(1'b0, ADDR_WIDTH'(addr), lsu_size_e'(2'(s)), '0, rdata, error);
                check("rsp_error_o", 64'(0), 64'(error));
                check("rsp_rdata_o", model_load(addr, nbytes), rdata);

                if (s != 3) begin
                    addr = addr & ~7;  // whole word around a partial store
                    access(1'b0, ADDR_WIDTH'(addr), DOUBLE, '0, rdata, error);
                    check("rsp_error_o", 64'(0), 64'(error));
                    check("rsp_rdata_o", model_load(addr, 8), rdata);
                end
            end
        end

        for (int n = 0; n < N_OOR; n++) begin
            widx = (ADDR_WIDTH-3)'(MEM_WORDS + ($urandom % ((1 << 29) - MEM_WORDS)));
            data = {$urandom, $urandom};
            access(1'b1, {widx, 3'b000}, DOUBLE, data, rdata, error);
            check("rsp_error_o", 64'(1), 64'(error));

            access(1'b0, {widx, 3'b000}, DOUBLE, '0, rdata, error);
            check("rsp_error_o", 64'(1), 64'(error));
            check("rsp_rdata_o", 64'(0), rdata);

            // word with the same low index bits must be untouched
            addr = int'(widx % MEM_WORDS) * 8;
            access(1'b0, ADDR_WIDTH'(addr), DOUBLE, '0, rdata, error);
            check("rsp_error_o", 64'(0), 64'(error));
            check("rsp_rdata_o", model_load(addr, 8), rdata);
        end

        $display("%0d errors in %0d checks", n_errors, n_checks);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
axi_pkg.sv
lsu_pkg.sv
latency_timer.sv
lsu_data_align.sv
lsu_ctrl_fsm.sv
axi_mem_slave.sv
lsu_axi_top.sv
tb_lsu_axi.sv

/* Makefile */
# Verilator build and run of the load/store AXI bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_axi
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
